// ==== hdl/robPkg.sv ====
// ==========================================================
// Machine-wide widths shared by every block in the core that
// carries a ROB tag or a data operand. Modules refer to these
// by scoped name and do not import the package.
// ==========================================================

package robPkg;

  // operands, PCs and results are all one machine word wide.
  parameter int dataWidth = 32;

  // the ROB has eight entries, so a tag needs three bits.
  parameter int robTagWidth = 3;

endpackage

// ==== hdl/branchOpPkg.sv ====
// ==========================================================
// Branch and jump operation codes carried from dispatch
// through the reservation station to the execute stage.
// Refer to them by scoped name.
// ==========================================================

package branchOpPkg;

  parameter int branchOpWidth = 3; // encoded width of branchOp.

  // conditional branches reuse the RISC-V funct3 encoding, so decode can pass funct3 through.
  // the two jumps take the encodings that funct3 leaves unused for branches.
  typedef enum logic [branchOpWidth-1:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    JAL  = 3'b010, // direct jump, target is already absolute.
    JALR = 3'b011, // indirect jump, target is an offset added to src1.
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branchOp;

endpackage

// ==== hdl/branchRsEntry.sv ====
// ==========================================================
// One entry of the branch reservation station. It holds a
// waiting branch, snoops the CDB for its pending operands and
// raises selectReq once both are available. The station top
// level instantiates one per slot.
// ==========================================================

module branchRsEntry (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                flush,
  input  logic                                write,
  input  logic                                grant,
  input  logic                                issueEnable,
  input  logic                                cdbValid,
  input  logic [robPkg::robTagWidth-1:0]      cdbRob,
  input  logic [robPkg::dataWidth-1:0]        cdbResult,
  input  branchOpPkg::branchOp                op,
  input  logic [robPkg::robTagWidth-1:0]      rob,
  input  logic                                ready1,
  input  logic                                ready2,
  input  logic [robPkg::dataWidth-1:0]        value1,
  input  logic [robPkg::dataWidth-1:0]        value2,
  input  logic [robPkg::robTagWidth-1:0]      rob1,
  input  logic [robPkg::robTagWidth-1:0]      rob2,
  input  logic [robPkg::dataWidth-1:0]        predictedPc,
  input  logic [robPkg::dataWidth-1:0]        target,
  input  logic [robPkg::dataWidth-1:0]        seqPc,
  output logic                                busy,
  output logic                                selectReq,
  output branchOpPkg::branchOp                entryOp,
  output logic [robPkg::robTagWidth-1:0]      entryRob,
  output logic [robPkg::dataWidth-1:0]        src1,
  output logic [robPkg::dataWidth-1:0]        src2,
  output logic [robPkg::dataWidth-1:0]        entryPredictedPc,
  output logic [robPkg::dataWidth-1:0]        entryTarget,
  output logic [robPkg::dataWidth-1:0]        entrySeqPc
);

  logic                           value1Ready, value2Ready; // operand already held in the entry.
  logic [robPkg::dataWidth-1:0]   val1, val2;               // stored operand values.
  logic [robPkg::robTagWidth-1:0] src1Rob, src2Rob;         // tags of the producing instructions.
  logic                           match1, match2;
  logic                           cdbHit1, cdbHit2;

  // a match only counts while the entry is live and the operand is still missing.
  assign match1 = busy & ~value1Ready & cdbValid & (cdbRob == src1Rob);
  assign match2 = busy & ~value2Ready & cdbValid & (cdbRob == src2Rob);

  // the producer can broadcast in the very cycle this branch is dispatched.
  assign cdbHit1 = cdbValid & ~ready1 & (cdbRob == rob1);
  assign cdbHit2 = cdbValid & ~ready2 & (cdbRob == rob2);

  // forwarding lets the last operand wake the entry in the broadcast cycle.
  assign src1 = match1 ? cdbResult : val1;
  assign src2 = match2 ? cdbResult : val2;
  assign selectReq = busy & (value1Ready | match1) & (value2Ready | match2);

  always_ff @(posedge clk) begin
    if (reset || flush) begin // flush wins over a dispatch in the same cycle.
      busy        <= 1'b0;
      value1Ready <= 1'b0;
      value2Ready <= 1'b0;
    end else if (write) begin
      busy        <= 1'b1;
      value1Ready <= ready1 | cdbHit1;
      value2Ready <= ready2 | cdbHit2;
    end else begin
      if (grant && issueEnable) busy <= 1'b0; // the branch leaves for execute.
      if (match1) value1Ready <= 1'b1;
      if (match2) value2Ready <= 1'b1;
    end
  end

  // payload only means something while busy is set.
  always_ff @(posedge clk) begin
    if (write) begin
      entryOp          <= op;
      entryRob         <= rob;
      src1Rob          <= rob1;
      src2Rob          <= rob2;
      val1             <= cdbHit1 ? cdbResult : value1;
      val2             <= cdbHit2 ? cdbResult : value2;
      entryPredictedPc <= predictedPc;
      entryTarget      <= target;
      entrySeqPc       <= seqPc;
    end else begin
      if (match1) val1 <= cdbResult;
      if (match2) val2 <= cdbResult;
    end
  end

  // the select block must only write a free slot.
  writeFreeSlot : assert property (@(posedge clk) disable iff (reset) write |-> !busy);

  // a grant for an entry that is not ready would issue stale operands.
  grantNeedsReq : assert property (@(posedge clk) disable iff (reset) grant |-> selectReq);

endmodule

// ==== hdl/branchRsSelect.sv ====
// ==========================================================
// Dispatch and issue selection for the branch reservation
// station. Picks the lowest free slot for a new branch and the
// lowest requesting slot for issue, both as one-hot vectors.
// ==========================================================

module branchRsSelect #(
  parameter int numEntries = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  dispatch,
  input  logic                  issueEnable,
  input  logic [numEntries-1:0] busy,
  input  logic [numEntries-1:0] request,
  output logic [numEntries-1:0] writeSel,
  output logic [numEntries-1:0] grant,
  output logic                  dispatchReady
);

  logic [numEntries-1:0] freeVec;
  logic [numEntries-1:0] lowestFree;
  logic [numEntries-1:0] lowestReq;

  assign freeVec = ~busy;

  // x & -x isolates the lowest set bit, which gives lowest index priority.
  assign lowestFree = freeVec & (~freeVec + 1'b1);
  assign lowestReq  = request & (~request + 1'b1);

  assign dispatchReady = |freeVec; // drops only when every slot holds a branch.

  assign writeSel = dispatch ? lowestFree : '0;
  assign grant    = issueEnable ? lowestReq : '0; // back-pressure holds every entry.

  // the dispatch stage has to watch dispatchReady before sending.
  dispatchWhenReady : assert property (@(posedge clk) disable iff (reset)
    dispatch |-> dispatchReady);

  // a grant to an empty slot would send a stale payload into execute.
  grantToBusy : assert property (@(posedge clk) disable iff (reset) (grant & ~busy) == '0);

endmodule

// ==== hdl/branchExecute.sv ====
// ==========================================================
// Single-cycle branch resolution stage. Evaluates the branch
// condition of the issued instruction, forms the actual next
// PC and compares it with the prediction. All outcomes are
// registered and leave one edge after issue.
// ==========================================================

module branchExecute (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           issue,
  input  branchOpPkg::branchOp           op,
  input  logic [robPkg::robTagWidth-1:0] rob,
  input  logic [robPkg::dataWidth-1:0]   src1,
  input  logic [robPkg::dataWidth-1:0]   src2,
  input  logic [robPkg::dataWidth-1:0]   predictedPc,
  input  logic [robPkg::dataWidth-1:0]   target,
  input  logic [robPkg::dataWidth-1:0]   seqPc,
  output logic                           brValid,
  output logic [robPkg::robTagWidth-1:0] brRob,
  output logic                           brTaken,
  output logic [robPkg::dataWidth-1:0]   brNextPc,
  output logic [robPkg::dataWidth-1:0]   brLink,
  output logic                           brMispredict
);

  logic                         taken;
  logic [robPkg::dataWidth-1:0] jalrPc;
  logic [robPkg::dataWidth-1:0] nextPc;

  // JALR clears bit 0 of the sum as the ISA requires.
  assign jalrPc = (src1 + target) & ~robPkg::dataWidth'(1);

  always_comb begin
    case (op)
      branchOpPkg::BEQ:  taken = (src1 == src2);
      branchOpPkg::BNE:  taken = (src1 != src2);
      branchOpPkg::BLT:  taken = ($signed(src1) < $signed(src2));
      branchOpPkg::BGE:  taken = ($signed(src1) >= $signed(src2));
      branchOpPkg::BLTU: taken = (src1 < src2);
      branchOpPkg::BGEU: taken = (src1 >= src2);
      default:           taken = 1'b1; // JAL and JALR always redirect.
    endcase
  end

  always_comb begin
    if (op == branchOpPkg::JALR) nextPc = jalrPc;
    else if (taken)              nextPc = target; // target is absolute for branches and JAL.
    else                         nextPc = seqPc;
  end

  always_ff @(posedge clk) begin
    if (reset) brValid <= 1'b0;
    else       brValid <= issue; // one result per issue, one edge later.
  end

  // the ROB ignores the payload unless brValid is high.
  always_ff @(posedge clk) begin
    if (issue) begin
      brRob        <= rob;
      brTaken      <= taken;
      brNextPc     <= nextPc;
      brLink       <= seqPc; // link value for rd, written even when rd is x0.
      brMispredict <= (nextPc != predictedPc);
    end
  end

  // the granted entry has to hand over a decoded operation.
  knownOp : assert property (@(posedge clk) disable iff (reset) issue |-> !$isunknown(op));

endmodule

// ==== hdl/branchStation.sv ====
// ==========================================================
// Top level of the branch reservation station. Holds up to
// numEntries waiting branches, wakes them from the CDB and
// feeds one granted branch per cycle into the execute stage.
// Dispatch, CDB, flush and issueEnable are plain strobes.
// ==========================================================

module branchStation #(
  parameter int numEntries = 4
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           flush,
  input  logic                           issueEnable,
  input  logic                           dispatch,
  input  branchOpPkg::branchOp           dispOp,
  input  logic [robPkg::robTagWidth-1:0] dispRob,
  input  logic                           dispReady1,
  input  logic                           dispReady2,
  input  logic [robPkg::dataWidth-1:0]   dispValue1,
  input  logic [robPkg::dataWidth-1:0]   dispValue2,
  input  logic [robPkg::robTagWidth-1:0] dispRob1,
  input  logic [robPkg::robTagWidth-1:0] dispRob2,
  input  logic [robPkg::dataWidth-1:0]   dispPredictedPc,
  input  logic [robPkg::dataWidth-1:0]   dispTarget,
  input  logic [robPkg::dataWidth-1:0]   dispSeqPc,
  input  logic                           cdbValid,
  input  logic [robPkg::robTagWidth-1:0] cdbRob,
  input  logic [robPkg::dataWidth-1:0]   cdbResult,
  output logic                           dispatchReady,
  output logic                           brValid,
  output logic [robPkg::robTagWidth-1:0] brRob,
  output logic                           brTaken,
  output logic [robPkg::dataWidth-1:0]   brNextPc,
  output logic [robPkg::dataWidth-1:0]   brLink,
  output logic                           brMispredict
);

  logic [numEntries-1:0]          busy, selectReq, writeSel, grant;
  branchOpPkg::branchOp           entryOp          [numEntries];
  logic [robPkg::robTagWidth-1:0] entryRob         [numEntries];
  logic [robPkg::dataWidth-1:0]   entrySrc1        [numEntries];
  logic [robPkg::dataWidth-1:0]   entrySrc2        [numEntries];
  logic [robPkg::dataWidth-1:0]   entryPredictedPc [numEntries];
  logic [robPkg::dataWidth-1:0]   entryTarget      [numEntries];
  logic [robPkg::dataWidth-1:0]   entrySeqPc       [numEntries];

  branchOpPkg::branchOp           exOp;
  logic [robPkg::robTagWidth-1:0] exRob;
  logic [robPkg::dataWidth-1:0]   exSrc1, exSrc2, exPredictedPc, exTarget, exSeqPc;
  logic                           issue;

  branchRsSelect #(.numEntries(numEntries)) u_select (
    .clk(clk), .reset(reset), .dispatch(dispatch), .issueEnable(issueEnable),
    .busy(busy), .request(selectReq), .writeSel(writeSel), .grant(grant),
    .dispatchReady(dispatchReady)
  );

  // every entry sees the same dispatch fields, writeSel decides which one keeps them.
  for (genvar i = 0; i < numEntries; i++) begin : gEntry
    branchRsEntry u_entry (
      .clk(clk), .reset(reset), .flush(flush), .write(writeSel[i]), .grant(grant[i]),
      .issueEnable(issueEnable), .cdbValid(cdbValid), .cdbRob(cdbRob), .cdbResult(cdbResult),
      .op(dispOp), .rob(dispRob), .ready1(dispReady1), .ready2(dispReady2),
      .value1(dispValue1), .value2(dispValue2), .rob1(dispRob1), .rob2(dispRob2),
      .predictedPc(dispPredictedPc), .target(dispTarget), .seqPc(dispSeqPc),
      .busy(busy[i]), .selectReq(selectReq[i]), .entryOp(entryOp[i]),
      .entryRob(entryRob[i]), .src1(entrySrc1[i]), .src2(entrySrc2[i]),
      .entryPredictedPc(entryPredictedPc[i]), .entryTarget(entryTarget[i]),
      .entrySeqPc(entrySeqPc[i])
    );
  end

  assign issue = |grant; // grant is one-hot, so any bit means one branch leaves.

  // grant is one-hot or zero, so the first match is the only match.
  always_comb begin
    exOp          = branchOpPkg::BEQ;
    exRob         = '0;
    exSrc1        = '0;
    exSrc2        = '0;
    exPredictedPc = '0;
    exTarget      = '0;
    exSeqPc       = '0;
    for (int i = 0; i < numEntries; i++) begin
      if (grant[i]) begin
        exOp          = entryOp[i];
        exRob         = entryRob[i];
        exSrc1        = entrySrc1[i]; // already carries any CDB forward.
        exSrc2        = entrySrc2[i];
        exPredictedPc = entryPredictedPc[i];
        exTarget      = entryTarget[i];
        exSeqPc       = entrySeqPc[i];
      end
    end
  end

  // execute ignores flush, the ROB drops a result that belongs to a squashed branch.
  branchExecute u_execute (
    .clk(clk), .reset(reset), .issue(issue), .op(exOp), .rob(exRob),
    .src1(exSrc1), .src2(exSrc2), .predictedPc(exPredictedPc), .target(exTarget),
    .seqPc(exSeqPc), .brValid(brValid), .brRob(brRob), .brTaken(brTaken),
    .brNextPc(brNextPc), .brLink(brLink), .brMispredict(brMispredict)
  );

endmodule

// ==== verif/clockGen.sv ====
// ==========================================================
// Clock and reset source for the branch station testbench.
// Drives a 40 ns clock and holds reset high for 16 cycles.
// ==========================================================

module clockGen (
  output logic clk,
  output logic reset
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int resetCycles = 16;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // half of the 40 ns period.
  end

  // reset drops 2 ns after an edge, the same point where every other input changes.
  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge clk);
    #2 reset = 1'b0;
  end

endmodule

// ==== verif/branchStationTb.sv ====
// ==========================================================
// Directed testbench for the branch reservation station.
// Runs resolution, CDB wakeup, misprediction, back-pressure
// and flush tests against a model of the branch rules.
// ==========================================================

module branchStationTb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int numEntries    = 4;
  localparam int timeoutCycles = 2000; // the directed tests take about 140 cycles.

  logic                           clk, reset;
  logic                           flush, issueEnable, dispatch;
  branchOpPkg::branchOp           dispOp;
  logic [robPkg::robTagWidth-1:0] dispRob, dispRob1, dispRob2, cdbRob, brRob;
  logic                           dispReady1, dispReady2, cdbValid;
  logic [robPkg::dataWidth-1:0]   dispValue1, dispValue2, dispPredictedPc, dispTarget;
  logic [robPkg::dataWidth-1:0]   dispSeqPc, cdbResult, brNextPc, brLink;
  logic                           dispatchReady, brValid, brTaken, brMispredict;
  integer                         seed = 50;
  int                             cycleCount = 0;

  clockGen u_clock (.clk(clk), .reset(reset));

  branchStation #(.numEntries(numEntries)) u_dut (
    .clk(clk), .reset(reset), .flush(flush), .issueEnable(issueEnable), .dispatch(dispatch),
    .dispOp(dispOp), .dispRob(dispRob), .dispReady1(dispReady1), .dispReady2(dispReady2),
    .dispValue1(dispValue1), .dispValue2(dispValue2), .dispRob1(dispRob1),
    .dispRob2(dispRob2), .dispPredictedPc(dispPredictedPc), .dispTarget(dispTarget),
    .dispSeqPc(dispSeqPc), .cdbValid(cdbValid), .cdbRob(cdbRob), .cdbResult(cdbResult),
    .dispatchReady(dispatchReady), .brValid(brValid), .brRob(brRob), .brTaken(brTaken),
    .brNextPc(brNextPc), .brLink(brLink), .brMispredict(brMispredict)
  );

  task automatic reportFailure(input string line);
    $display("%s", line);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  // one clock, landing at the drive point 2 ns after the edge.
  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  // reference resolution, taken directly from the branch rules.
  task automatic modelBranch(input branchOpPkg::branchOp op,
      input logic [robPkg::dataWidth-1:0] s1, s2, target, seqPc, predicted,
      output logic taken, output logic [robPkg::dataWidth-1:0] nextPc,
      output logic mispredict);
    logic signed [robPkg::dataWidth-1:0] sa, sb;
    logic [robPkg::dataWidth-1:0]        jumpSum;
    sa = s1;
    sb = s2;
    jumpSum = s1 + target;
    case (op)
      branchOpPkg::BEQ, branchOpPkg::BNE:   taken = (s1 == s2) ^ (op == branchOpPkg::BNE);
      branchOpPkg::BLT, branchOpPkg::BGE:   taken = (sa < sb) ^ (op == branchOpPkg::BGE);
      branchOpPkg::BLTU, branchOpPkg::BGEU: taken = (s1 < s2) ^ (op == branchOpPkg::BGEU);
      default:                              taken = 1'b1; // both jumps.
    endcase
    if (op == branchOpPkg::JALR) nextPc = {jumpSum[robPkg::dataWidth-1:1], 1'b0};
    else nextPc = taken ? target : seqPc;
    mispredict = (nextPc != predicted);
  endtask

  task automatic checkResult(input logic [robPkg::robTagWidth-1:0] expRob, input logic expTaken,
      input logic [robPkg::dataWidth-1:0] expNextPc, expLink, input logic expMispredict);
    if (brRob !== expRob || brTaken !== expTaken || brNextPc !== expNextPc ||
        brLink !== expLink || brMispredict !== expMispredict)
      reportFailure($sformatf(
        "[ERROR] %0t result rob %0d taken %b next %h link %h mis %b, want %0d %b %h %h %b",
        $time, brRob, brTaken, brNextPc, brLink, brMispredict,
        expRob, expTaken, expNextPc, expLink, expMispredict));
  endtask

  task automatic checkLevel(input logic expReady, input logic expValid);
    if (dispatchReady !== expReady || brValid !== expValid)
      reportFailure($sformatf("[ERROR] %0t dispatchReady %b brValid %b, want %b %b",
        $time, dispatchReady, brValid, expReady, expValid));
  endtask

  // raises dispatch with all fields; the caller ticks and lowers it.
  task automatic driveDispatch(input branchOpPkg::branchOp op,
      input logic [robPkg::robTagWidth-1:0] rob, input logic r1, r2,
      input logic [robPkg::dataWidth-1:0] v1, v2, input logic [robPkg::robTagWidth-1:0] t1, t2,
      input logic [robPkg::dataWidth-1:0] predicted, target, seqPc);
    dispatch = 1'b1;
    dispOp = op;
    dispRob = rob;
    dispReady1 = r1;
    dispReady2 = r2;
    dispValue1 = v1;
    dispValue2 = v2;
    dispRob1 = t1;
    dispRob2 = t2;
    dispPredictedPc = predicted;
    dispTarget = target;
    dispSeqPc = seqPc;
  endtask

  // a ready branch leaves execute two edges after dispatch.
  task automatic resolveOne(input branchOpPkg::branchOp op,
      input logic [robPkg::robTagWidth-1:0] rob,
      input logic [robPkg::dataWidth-1:0] s1, s2, target, seqPc, predicted);
    logic                         taken, mispredict;
    logic [robPkg::dataWidth-1:0] nextPc;
    modelBranch(op, s1, s2, target, seqPc, predicted, taken, nextPc, mispredict);
    driveDispatch(op, rob, 1'b1, 1'b1, s1, s2, '0, '0, predicted, target, seqPc);
    tick();
    dispatch = 1'b0;
    checkLevel(1'b1, 1'b0);
    tick();
    checkLevel(1'b1, 1'b1);
    checkResult(rob, taken, nextPc, seqPc, mispredict);
  endtask

  task automatic testResolution();
    logic [robPkg::dataWidth-1:0] a, b, target, seqPc;
    for (int i = 0; i < 8; i++) begin
      for (int k = 0; k < 4; k++) begin
        target = $random(seed) & ~32'h3;
        seqPc = $random(seed) & ~32'h3;
        case (k)
          0: begin
            a = $random(seed);
            b = $random(seed);
          end
          1: begin
            a = $random(seed);
            b = a;
          end
          2: begin
            a = 32'h8000_0000; // signed less, unsigned greater.
            b = 32'h1;
          end
          default: begin
            a = 32'h7fff_ffff;
            b = 32'h8000_0000;
          end
        endcase
        resolveOne(branchOpPkg::branchOp'(i), robPkg::robTagWidth'(i + k), a, b, target,
                   seqPc, target);
      end
    end
  endtask

  task automatic testWakeup();
    logic [robPkg::dataWidth-1:0] a, b, target, seqPc, nextPc;
    logic                         taken, mispredict;
    a = $random(seed);
    b = $random(seed);
    target = $random(seed) & ~32'h3;
    seqPc = $random(seed) & ~32'h3;
    modelBranch(branchOpPkg::BLTU, a, b, target, seqPc, seqPc, taken, nextPc, mispredict);
    driveDispatch(branchOpPkg::BLTU, 3'd4, 1'b0, 1'b0, 32'hdead_beef, 32'hdead_beef,
                  3'd3, 3'd5, seqPc, target, seqPc);
    tick();
    dispatch = 1'b0;
    checkLevel(1'b1, 1'b0);
    cdbValid = 1'b1; // first operand only, still waiting on tag 5.
    cdbRob = 3'd3;
    cdbResult = a;
    tick();
    cdbValid = 1'b0;
    checkLevel(1'b1, 1'b0);
    tick();
    checkLevel(1'b1, 1'b0);
    cdbValid = 1'b1; // last operand issues in its own broadcast cycle.
    cdbRob = 3'd5;
    cdbResult = b;
    tick();
    cdbValid = 1'b0;
    checkLevel(1'b1, 1'b1);
    checkResult(3'd4, taken, nextPc, seqPc, mispredict);
    // now the producer broadcasts in the same cycle as the dispatch.
    modelBranch(branchOpPkg::BGE, b, a, target, seqPc, target, taken, nextPc, mispredict);
    driveDispatch(branchOpPkg::BGE, 3'd6, 1'b1, 1'b0, b, 32'h0, 3'd0, 3'd2,
                  target, target, seqPc);
    cdbValid = 1'b1;
    cdbRob = 3'd2;
    cdbResult = a;
    tick();
    dispatch = 1'b0;
    cdbValid = 1'b0;
    checkLevel(1'b1, 1'b0);
    tick();
    checkLevel(1'b1, 1'b1);
    checkResult(3'd6, taken, nextPc, seqPc, mispredict);
  endtask

  task automatic testMispredict();
    logic [robPkg::dataWidth-1:0] a, b, target, seqPc, nextPc;
    logic                         taken, mispredict;
    for (int i = 0; i < 8; i++) begin
      a = $random(seed);
      b = (i % 2) ? a : $random(seed);
      target = $random(seed) & ~32'h3;
      seqPc = $random(seed) & ~32'h3;
      modelBranch(branchOpPkg::branchOp'(i), a, b, target, seqPc, '0, taken, nextPc, mispredict);
      resolveOne(branchOpPkg::branchOp'(i), robPkg::robTagWidth'(i), a, b, target, seqPc,
                 nextPc); // correct prediction.
      resolveOne(branchOpPkg::branchOp'(i), robPkg::robTagWidth'(i), a, b, target, seqPc,
                 nextPc ^ 32'h10);
    end
  endtask

  task automatic testBackPressure();
    logic [robPkg::dataWidth-1:0] a, b, target;
    logic [robPkg::dataWidth-1:0] seqPc [numEntries];
    logic [robPkg::dataWidth-1:0] nextPc [numEntries];
    logic                         taken [numEntries];
    logic                         mispredict [numEntries];
    issueEnable = 1'b0;
    for (int i = 0; i < numEntries; i++) begin
      a = $random(seed);
      b = $random(seed);
      target = $random(seed) & ~32'h3;
      seqPc[i] = $random(seed) & ~32'h3;
      modelBranch(branchOpPkg::branchOp'(i + 4), a, b, target, seqPc[i], seqPc[i],
                  taken[i], nextPc[i], mispredict[i]);
      driveDispatch(branchOpPkg::branchOp'(i + 4), robPkg::robTagWidth'(i), 1'b1, 1'b1, a, b,
                    '0, '0, seqPc[i], target, seqPc[i]);
      tick();
      dispatch = 1'b0;
      checkLevel(i < numEntries - 1, 1'b0); // ready drops once the last slot fills.
    end
    repeat (2) begin
      tick();
      checkLevel(1'b0, 1'b0);
    end
    issueEnable = 1'b1;
    for (int i = 0; i < numEntries; i++) begin
      tick();
      checkLevel(1'b1, 1'b1);
      checkResult(robPkg::robTagWidth'(i), taken[i], nextPc[i], seqPc[i], mispredict[i]);
    end
    tick();
    checkLevel(1'b1, 1'b0);
  endtask

  task automatic testFlush();
    driveDispatch(branchOpPkg::BEQ, 3'd1, 1'b0, 1'b1, 32'h0, 32'h5, 3'd6, 3'd0,
                  32'h100, 32'h200, 32'h104);
    tick();
    driveDispatch(branchOpPkg::BNE, 3'd2, 1'b1, 1'b0, 32'h7, 32'h0, 3'd0, 3'd7,
                  32'h300, 32'h400, 32'h304);
    tick();
    dispatch = 1'b0;
    checkLevel(1'b1, 1'b0);
    flush = 1'b1; // a ready dispatch in the flush cycle is dropped too.
    driveDispatch(branchOpPkg::JAL, 3'd3, 1'b1, 1'b1, 32'h0, 32'h0, 3'd0, 3'd0,
                  32'h500, 32'h600, 32'h504);
    tick();
    flush = 1'b0;
    dispatch = 1'b0;
    checkLevel(1'b1, 1'b0);
    cdbValid = 1'b1;
    cdbRob = 3'd6;
    cdbResult = $random(seed);
    tick();
    checkLevel(1'b1, 1'b0);
    cdbRob = 3'd7;
    tick();
    cdbValid = 1'b0;
    checkLevel(1'b1, 1'b0);
    tick();
    checkLevel(1'b1, 1'b0);
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles)
      reportFailure($sformatf("timeout: the tests did not finish within %0d cycles",
                              timeoutCycles));
  end

  initial begin
    flush = 1'b0;
    issueEnable = 1'b1;
    dispatch = 1'b0;
    dispOp = branchOpPkg::BEQ;
    dispRob = '0;
    dispReady1 = 1'b0;
    dispReady2 = 1'b0;
    dispValue1 = '0;
    dispValue2 = '0;
    dispRob1 = '0;
    dispRob2 = '0;
    dispPredictedPc = '0;
    dispTarget = '0;
    dispSeqPc = '0;
    cdbValid = 1'b0;
    cdbRob = '0;
    cdbResult = '0;
    @(negedge reset);
    checkLevel(1'b1, 1'b0); // empty station after reset.
    testResolution();
    testWakeup();
    testMispredict();
    testBackPressure();
    testFlush();
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== compile.f ====
hdl/robPkg.sv
hdl/branchOpPkg.sv
hdl/branchRsEntry.sv
hdl/branchRsSelect.sv
hdl/branchExecute.sv
hdl/branchStation.sv
verif/clockGen.sv
verif/branchStationTb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it, the exit status is the test result.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module branchStationTb \
  -f compile.f -o simv &&
./obj_dir/simv || exit 1
